// ==== rtl/isa_pkg.sv ====
// instruction set encoding, referenced by scoped name from the decoder, immediate unit and ALU
package isa_pkg;

  // instruction field positions, given as low bit and width
  localparam int opcode_lsb   = 25;
  localparam int opcode_width = 6;

  localparam int rd_lsb  = 20;
  localparam int rs1_lsb = 15;
  localparam int rs2_lsb = 10;

  localparam int shamt_lsb   = 10; // shares bits with rs2
  localparam int shamt_width = 5;

  localparam int subop_lsb   = 0;
  localparam int subop_width = 5;

  localparam int imm15_lsb   = 0;
  localparam int imm15_width = 15;

  localparam int imm20_lsb   = 0;
  localparam int imm20_width = 20;

  // major opcode in bits 30..25
  typedef enum logic [opcode_width-1:0] {
    op_alu  = 6'b100000, // register ops and immediate shifts
    op_movi = 6'b100010,
    op_addi = 6'b101000,
    op_xori = 6'b101011,
    op_ori  = 6'b101100
  } opcode_t;

  // sub-opcode under op_alu, also the ALU operation code
  typedef enum logic [subop_width-1:0] {
    alu_add   = 5'b00000,
    alu_sub   = 5'b00001,
    alu_and   = 5'b00010,
    alu_xor   = 5'b00011,
    alu_or    = 5'b00100,
    alu_slli  = 5'b01000,
    alu_srli  = 5'b01001, // nop shares this code
    alu_rotri = 5'b01011
  } subop_t;

endpackage

// ==== rtl/core_pkg.sv ====
// microarchitecture types shared by the core RTL and its testbench
package core_pkg;

  // trace record widths, match the default core configuration
  localparam int trace_data_width = 32;
  localparam int trace_addr_width = 5;

  // sequencer states
  typedef enum logic [1:0] {
    stop  = 2'b00,
    fetch = 2'b01,
    exe   = 2'b10,
    write = 2'b11
  } state_t;

  // immediate kind
  typedef enum logic [1:0] {
    imm5_ze  = 2'b00,
    imm15_se = 2'b01,
    imm15_ze = 2'b10,
    imm20_se = 2'b11
  } imm_sel_t;

  // writeback source
  typedef enum logic {
    alu_result = 1'b0,
    immediate  = 1'b1
  } wb_sel_t;

  // one control word per cycle from the controller
  typedef struct packed {
    logic             enable_fetch;
    logic             enable_execute;
    logic             enable_writeback;
    imm_sel_t         imm_sel;
    logic             use_imm;   // alu operand b from immediate
    wb_sel_t          wb_sel;
    isa_pkg::subop_t  alu_op;
  } ctrl_t;

  // register write as seen at the core boundary
  typedef struct packed {
    logic                        valid;
    logic [trace_addr_width-1:0] rd;
    logic [trace_data_width-1:0] data;
  } wb_trace_t;

endpackage

// ==== rtl/controller.sv ====
// four-state sequencer, decodes the current instruction into a control word every cycle
module controller #(
  parameter int data_width = 32
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic [data_width-1:0] instr,
  output core_pkg::ctrl_t       ctrl,
  output core_pkg::state_t      state
);

  core_pkg::state_t  state_next;
  isa_pkg::opcode_t  opcode;
  isa_pkg::subop_t   subop;
  logic              is_shift;

  assign opcode = isa_pkg::opcode_t'(instr[isa_pkg::opcode_lsb +: isa_pkg::opcode_width]);
  assign subop  = isa_pkg::subop_t'(instr[isa_pkg::subop_lsb +: isa_pkg::subop_width]);

  assign is_shift = subop inside {isa_pkg::alu_srli, isa_pkg::alu_slli, isa_pkg::alu_rotri};

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= core_pkg::stop;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    case (state)
      core_pkg::stop:  state_next = core_pkg::fetch;
      core_pkg::fetch: begin
        // movi has nothing to compute
        if (opcode == isa_pkg::op_movi) begin
          state_next = core_pkg::write;
        end else begin
          state_next = core_pkg::exe;
        end
      end
      core_pkg::exe:   state_next = core_pkg::write;
      default:         state_next = core_pkg::stop;
    endcase
  end

  always_comb begin
    ctrl.enable_fetch     = (state == core_pkg::fetch);
    ctrl.enable_execute   = (state == core_pkg::exe);
    ctrl.enable_writeback = (state == core_pkg::write);
    ctrl.imm_sel          = core_pkg::imm5_ze;
    ctrl.use_imm          = 1'b0;
    ctrl.wb_sel           = core_pkg::alu_result;
    ctrl.alu_op           = subop;
    case (opcode)
      isa_pkg::op_alu: begin
        ctrl.use_imm = is_shift; // shift amount sits in the rs2 field
      end
      isa_pkg::op_addi: begin
        ctrl.imm_sel = core_pkg::imm15_se;
        ctrl.use_imm = 1'b1;
        ctrl.alu_op  = isa_pkg::alu_add;
      end
      isa_pkg::op_ori: begin
        ctrl.imm_sel = core_pkg::imm15_ze;
        ctrl.use_imm = 1'b1;
        ctrl.alu_op  = isa_pkg::alu_or;
      end
      isa_pkg::op_xori: begin
        ctrl.imm_sel = core_pkg::imm15_ze;
        ctrl.use_imm = 1'b1;
        ctrl.alu_op  = isa_pkg::alu_xor;
      end
      isa_pkg::op_movi: begin
        ctrl.imm_sel = core_pkg::imm20_se;
        ctrl.wb_sel  = core_pkg::immediate;
      end
      default: begin
        ctrl.use_imm = 1'b0; // unknown opcode, register form
      end
    endcase
  end

  // latched word in execute must agree with the routing chosen in fetch
  a_movi_no_exe: assert property (@(posedge clock) disable iff (reset)
    ctrl.enable_execute |-> opcode != isa_pkg::op_movi)
    else $error("controller: movi reached the execute state");

  // state stays a known encoding once out of reset
  a_state_legal: assert property (@(posedge clock) disable iff (reset)
    state inside {core_pkg::stop, core_pkg::fetch, core_pkg::exe, core_pkg::write})
    else $error("controller: illegal state %b", state);

endmodule

// ==== rtl/imm_select.sv ====
// builds the immediate operand from the latched instruction by zero or sign extension
module imm_select #(
  parameter int data_width = 32
) (
  input  logic [data_width-1:0] instr,
  input  core_pkg::imm_sel_t    imm_sel,
  output logic [data_width-1:0] imm
);

  logic [isa_pkg::shamt_width-1:0] imm5;
  logic [isa_pkg::imm15_width-1:0] imm15;
  logic [isa_pkg::imm20_width-1:0] imm20;

  assign imm5  = instr[isa_pkg::shamt_lsb +: isa_pkg::shamt_width];
  assign imm15 = instr[isa_pkg::imm15_lsb +: isa_pkg::imm15_width];
  assign imm20 = instr[isa_pkg::imm20_lsb +: isa_pkg::imm20_width];

  always_comb begin
    case (imm_sel)
      core_pkg::imm5_ze: begin
        imm = data_width'(imm5); // shift amount
      end
      core_pkg::imm15_se: begin
        imm = {{(data_width - isa_pkg::imm15_width){imm15[isa_pkg::imm15_width-1]}}, imm15};
      end
      core_pkg::imm15_ze: begin
        imm = data_width'(imm15);
      end
      default: begin
        imm = {{(data_width - isa_pkg::imm20_width){imm20[isa_pkg::imm20_width-1]}}, imm20};
      end
    endcase
  end

endmodule

// ==== rtl/reg_file.sv ====
// register file, two combinational reads and one write, register zero fixed at zero
module reg_file #(
  parameter int data_width = 32,
  parameter int addr_width = 5
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic [addr_width-1:0] rs1,
  input  logic [addr_width-1:0] rs2,
  input  logic [addr_width-1:0] rd,
  input  logic                  write_enable,
  input  logic [data_width-1:0] write_data,
  output logic [data_width-1:0] rs1_data,
  output logic [data_width-1:0] rs2_data
);

  localparam int depth = 2 ** addr_width;

  logic [data_width-1:0] regs [depth];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < depth; i++) begin
        regs[i] <= '0;
      end
    end else if (write_enable && rd != '0) begin
      regs[rd] <= write_data; // r0 writes dropped
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  // controller must always drive a clean write strobe
  a_we_known: assert property (@(posedge clock) disable iff (reset)
    !$isunknown(write_enable))
    else $error("reg_file: write_enable unknown");

endmodule

// ==== rtl/alu.sv ====
// integer ALU for add, sub, logic, shifts and rotate, chosen by the operation code
module alu #(
  parameter int data_width = 32
) (
  input  isa_pkg::subop_t       alu_op,
  input  logic [data_width-1:0] a,
  input  logic [data_width-1:0] b,
  output logic [data_width-1:0] result
);

  logic [isa_pkg::shamt_width-1:0] shamt;
  logic [2*data_width-1:0]         rot_wide;

  assign shamt = b[isa_pkg::shamt_width-1:0]; // only low bits count

  // rotate as a shift of the doubled word
  assign rot_wide = {a, a} >> shamt;

  always_comb begin
    case (alu_op)
      isa_pkg::alu_add: begin
        result = a + b;
      end
      isa_pkg::alu_sub: begin
        result = a - b;
      end
      isa_pkg::alu_and: begin
        result = a & b;
      end
      isa_pkg::alu_or: begin
        result = a | b;
      end
      isa_pkg::alu_xor: begin
        result = a ^ b;
      end
      isa_pkg::alu_srli: begin
        result = a >> shamt;
      end
      isa_pkg::alu_slli: begin
        result = a << shamt;
      end
      isa_pkg::alu_rotri: begin
        result = rot_wide[data_width-1:0]; // low bits wrap to the top
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

// ==== rtl/cpu_core.sv ====
// multi-cycle core top, pc and instruction latch, wires controller and datapath
module cpu_core #(
  parameter int data_width = 32,
  parameter int addr_width = 5
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic [data_width-1:0] ir,
  output logic [data_width-1:0] pc,
  output core_pkg::wb_trace_t   wb
);

  core_pkg::ctrl_t       ctrl;
  core_pkg::state_t      state;
  logic [data_width-1:0] instr_q;
  logic [data_width-1:0] decode_word;
  logic [data_width-1:0] imm;
  logic [data_width-1:0] rs1_data;
  logic [data_width-1:0] rs2_data;
  logic [data_width-1:0] alu_b;
  logic [data_width-1:0] alu_out;
  logic [data_width-1:0] result_q;
  logic [data_width-1:0] write_data;
  logic [addr_width-1:0] rs1;
  logic [addr_width-1:0] rs2;
  logic [addr_width-1:0] rd;

  // the latch is not loaded yet in fetch, so decode the incoming word there
  assign decode_word = (state == core_pkg::fetch) ? ir : instr_q;

  always_ff @(posedge clock) begin
    if (ctrl.enable_fetch) begin
      instr_q <= ir;
    end
  end

  always_ff @(posedge clock) begin
    if (ctrl.enable_execute) begin
      result_q <= alu_out;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= '0;
    end else if (ctrl.enable_writeback) begin
      pc <= pc + data_width'(1); // one word per instruction
    end
  end

  assign rs1 = instr_q[isa_pkg::rs1_lsb +: addr_width];
  assign rs2 = instr_q[isa_pkg::rs2_lsb +: addr_width];
  assign rd  = instr_q[isa_pkg::rd_lsb +: addr_width];

  controller #(.data_width(data_width)) i_controller (
    .clock (clock),
    .reset (reset),
    .instr (decode_word),
    .ctrl  (ctrl),
    .state (state)
  );

  imm_select #(.data_width(data_width)) i_imm_select (
    .instr   (instr_q),
    .imm_sel (ctrl.imm_sel),
    .imm     (imm)
  );

  reg_file #(.data_width(data_width), .addr_width(addr_width)) i_reg_file (
    .clock        (clock),
    .reset        (reset),
    .rs1          (rs1),
    .rs2          (rs2),
    .rd           (rd),
    .write_enable (ctrl.enable_writeback),
    .write_data   (write_data),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data)
  );

  assign alu_b = ctrl.use_imm ? imm : rs2_data;

  alu #(.data_width(data_width)) i_alu (
    .alu_op (ctrl.alu_op),
    .a      (rs1_data),
    .b      (alu_b),
    .result (alu_out)
  );

  // movi writes the immediate, all others the registered alu result
  assign write_data = (ctrl.wb_sel == core_pkg::immediate) ? imm : result_q;

  assign wb.valid = ctrl.enable_writeback;
  assign wb.rd    = core_pkg::trace_addr_width'(rd);
  assign wb.data  = core_pkg::trace_data_width'(write_data);

endmodule

// ==== bench/clock_gen.sv ====
// testbench clock and reset source, reset held high for a set number of clock cycles
module clock_gen #(
  parameter int period       = 4,
  parameter int reset_cycles = 16
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #(period / 2) clock = ~clock;
  end

  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clock);
    reset <= 1'b0; // released on a rising edge
  end

endmodule

// ==== bench/cpu_core_tb.sv ====
// testbench for cpu_core, runs a fixed program table and checks every writeback event
module cpu_core_tb;

  localparam int period        = 4;
  localparam int reset_cycles  = 16;
  localparam int num_rows      = 28;
  localparam int margin_cycles = 32;
  localparam int watchdog_time = (num_rows * 4 + reset_cycles + margin_cycles) * period;

  typedef struct packed {
    logic [31:0] instr;
    logic [4:0]  rd;
    logic [31:0] data;
  } prog_row_t;

  logic                clock;
  logic                reset;
  logic [31:0]         ir;
  logic [31:0]         pc;
  core_pkg::wb_trace_t wb;

  prog_row_t prog [32];
  int        checks;
  int        value_errors;
  int        other_errors;
  int        retired;

  clock_gen #(.period(period), .reset_cycles(reset_cycles)) i_clock_gen (
    .clock (clock),
    .reset (reset)
  );

  cpu_core #(.data_width(32), .addr_width(5)) i_dut (
    .clock (clock),
    .reset (reset),
    .ir    (ir),
    .pc    (pc),
    .wb    (wb)
  );

  // register form, also used for the immediate shifts with rs2 as shift amount
  function automatic logic [31:0] encode_reg(isa_pkg::subop_t sub, int rd, int rs1, int rs2);
    logic [31:0] w;
    w = '0;
    w[30:25] = isa_pkg::op_alu;
    w[24:20] = 5'(rd);
    w[19:15] = 5'(rs1);
    w[14:10] = 5'(rs2);
    w[4:0]   = sub;
    return w;
  endfunction

  function automatic logic [31:0] encode_imm(isa_pkg::opcode_t op, int rd, int rs1,
                                             logic [14:0] imm15);
    logic [31:0] w;
    w = '0;
    w[30:25] = op;
    w[24:20] = 5'(rd);
    w[19:15] = 5'(rs1);
    w[14:0]  = imm15;
    return w;
  endfunction

  function automatic logic [31:0] encode_movi(int rd, logic [19:0] imm20);
    logic [31:0] w;
    w = '0;
    w[30:25] = isa_pkg::op_movi;
    w[24:20] = 5'(rd);
    w[19:0]  = imm20;
    return w;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    assert (actual === expected)
      else begin
        $display("Error at time %0t: %s is %h, expected %h", $time, name, actual, expected);
        value_errors++;
      end
  endtask

  task automatic report_and_finish();
    $display("summary: %0d checks, %0d value errors, %0d other errors, %0d of %0d retired",
             checks, value_errors, other_errors, retired, num_rows);
    if (value_errors == 0 && other_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  endtask

  initial begin : program_table
    for (int i = 0; i < 32; i++) begin
      prog[i] = '{encode_movi(0, 20'h00000), 5'd0, 32'h0}; // filler past the end
    end
    prog[0]  = '{encode_movi(1, 20'hffff0), 5'd1, 32'hfffffff0}; // negative, sign extended
    prog[1]  = '{encode_movi(2, 20'h12345), 5'd2, 32'h00012345};
    prog[2]  = '{encode_imm(isa_pkg::op_addi, 3, 2, 15'h7fff), 5'd3, 32'h00012344};
    prog[3]  = '{encode_imm(isa_pkg::op_ori, 4, 0, 15'h4001), 5'd4, 32'h00004001};
    prog[4]  = '{encode_imm(isa_pkg::op_xori, 5, 1, 15'h7fff), 5'd5, 32'hffff800f};
    prog[5]  = '{encode_imm(isa_pkg::op_addi, 6, 4, 15'h7000), 5'd6, 32'h00003001};
    prog[6]  = '{encode_reg(isa_pkg::alu_add, 8, 1, 2), 5'd8, 32'h00012335}; // wraps
    prog[7]  = '{encode_reg(isa_pkg::alu_sub, 9, 4, 2), 5'd9, 32'hffff1cbc};
    prog[8]  = '{encode_reg(isa_pkg::alu_and, 10, 5, 2), 5'd10, 32'h00010005};
    prog[9]  = '{encode_reg(isa_pkg::alu_or, 11, 6, 3), 5'd11, 32'h00013345};
    prog[10] = '{encode_reg(isa_pkg::alu_xor, 12, 8, 9), 5'd12, 32'hfffe3f89};
    prog[11] = '{encode_reg(isa_pkg::alu_srli, 13, 5, 0), 5'd13, 32'hffff800f};
    prog[12] = '{encode_reg(isa_pkg::alu_srli, 14, 5, 1), 5'd14, 32'h7fffc007};
    prog[13] = '{encode_reg(isa_pkg::alu_srli, 15, 5, 31), 5'd15, 32'h00000001};
    prog[14] = '{encode_reg(isa_pkg::alu_slli, 16, 5, 0), 5'd16, 32'hffff800f};
    prog[15] = '{encode_reg(isa_pkg::alu_slli, 17, 5, 1), 5'd17, 32'hffff001e};
    prog[16] = '{encode_reg(isa_pkg::alu_slli, 18, 5, 31), 5'd18, 32'h80000000};
    prog[17] = '{encode_reg(isa_pkg::alu_rotri, 19, 5, 0), 5'd19, 32'hffff800f};
    prog[18] = '{encode_reg(isa_pkg::alu_rotri, 20, 5, 1), 5'd20, 32'hffffc007};
    prog[19] = '{encode_reg(isa_pkg::alu_rotri, 21, 5, 31), 5'd21, 32'hffff001f};
    prog[20] = '{encode_reg(isa_pkg::alu_rotri, 22, 4, 4), 5'd22, 32'h10000400};
    prog[21] = '{encode_movi(0, 20'h00055), 5'd0, 32'h00000055}; // r0 target still traced
    prog[22] = '{encode_reg(isa_pkg::alu_add, 23, 0, 2), 5'd23, 32'h00012345};
    prog[23] = '{encode_imm(isa_pkg::op_ori, 24, 0, 15'h0f0f), 5'd24, 32'h00000f0f};
    prog[24] = '{encode_reg(isa_pkg::alu_sub, 25, 4, 0), 5'd25, 32'h00004001};
    prog[25] = '{encode_reg(isa_pkg::alu_xor, 0, 1, 2), 5'd0, 32'hfffedcb5};
    prog[26] = '{encode_reg(isa_pkg::alu_or, 26, 0, 0), 5'd26, 32'h00000000};
    prog[27] = '{encode_reg(isa_pkg::alu_add, 27, 12, 11), 5'd27, 32'hffff72ce};
  end

  // instruction supply, the word for the current pc
  initial begin : instr_driver
    ir = '0;
    forever begin
      @(posedge clock);
      if (pc < num_rows) begin
        ir <= prog[pc[4:0]].instr;
      end else begin
        ir <= prog[31].instr;
      end
    end
  end

  initial begin : trace_checker
    checks       = 0;
    value_errors = 0;
    retired      = 0;
    @(posedge clock); // first reset edge clears pc
    @(negedge clock);
    while (retired < num_rows) begin
      if (reset) begin
        check_value("pc", pc, 32'h0);
        check_value("wb.valid", 32'(wb.valid), 32'h0);
      end else begin
        check_value("pc", pc, 32'(retired)); // one step per retired instruction
        if (wb.valid) begin
          check_value("wb.rd", 32'(wb.rd), 32'(prog[retired].rd));
          check_value("wb.data", wb.data, prog[retired].data);
          retired++;
        end
      end
      @(negedge clock);
    end
    check_value("pc", pc, 32'(num_rows));
    check_value("wb.valid", 32'(wb.valid), 32'h0);
    report_and_finish();
  end

  initial begin : watchdog
    other_errors = 0;
    #(watchdog_time);
    $display("watchdog expired at time %0t, the program did not finish", $time);
    other_errors++;
    report_and_finish();
  end

endmodule

// ==== flist.f ====
rtl/isa_pkg.sv
rtl/core_pkg.sv
rtl/controller.sv
rtl/imm_select.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/cpu_core.sv
bench/clock_gen.sv
bench/cpu_core_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module cpu_core_tb -f flist.f -o cpu_core_sim \
  > sim.log 2>&1 &&
  ./obj_dir/cpu_core_sim >> sim.log 2>&1
cat sim.log
grep -q 'All tests passed!' sim.log && echo "simulation PASS" || {
  echo "simulation FAIL"
  exit 1
}
